/* tb.f */
+incdir+common
common/dma_pkg.sv
hw/dma_ctrl_regs.sv
hw/mrd_path/mrd_requester.sv
hw/mrd_path/rd_throttle.sv
hw/cpl_path/cpl_receiver.sv
hw/cpl_path/cpl_buffer.sv
hw/cpl_path/user_drain.sv
hw/dma_ep_top.sv
verif/dma_ep_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the read DMA endpoint testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f \
    --top-module dma_ep_tb \
    -Mdir obj_dir

./obj_dir/Vdma_ep_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

/* verif/dma_ep_tb.sv */
//--------------------
// Read DMA endpoint testbench
// Register stimulus, link completion model, user ack model and checks
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_ep_tb;
    import dma_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    dw_t       reg_wdata;
    dw_t       reg_rdata;
    logic      mrd_valid;
    logic      mrd_ready;
    addr_t     mrd_addr;
    len_t      mrd_len;
    tag_t      mrd_tag;
    logic      cpl_valid;
    logic      cpl_ready;
    dw_t       cpl_data;
    logic      cpl_err;
    logic      usr_req;
    logic      usr_ack;
    dw_t       usr_data;

    dw_t         pend_q[$];    // Requested words not yet returned
    dw_t         exp_q[$];     // Words the user should still see
    addr_t       xfer_base;
    int          xfer_len;
    int          poison_idx;   // Poisoned word index or -1
    int          req_words;
    int          req_cnt;
    int          cpl_cnt;
    int          outst;
    logic        hold_cpl;
    logic        usr_slow;
    logic        saw_full;
    int          val_errs;
    int          proto_errs;
    int          timeouts;
    int unsigned seed_val;
    int          held;
    int          a;

    dma_ep_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_i    (reg_wr),
        .reg_rd_i    (reg_rd),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .mrd_valid_o (mrd_valid),
        .mrd_ready_i (mrd_ready),
        .mrd_addr_o  (mrd_addr),
        .mrd_len_o   (mrd_len),
        .mrd_tag_o   (mrd_tag),
        .cpl_valid_i (cpl_valid),
        .cpl_ready_o (cpl_ready),
        .cpl_data_i  (cpl_data),
        .cpl_err_i   (cpl_err),
        .usr_req_o   (usr_req),
        .usr_ack_i   (usr_ack),
        .usr_data_o  (usr_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input dw_t got, input dw_t exp);
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input dw_t data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output dw_t data);
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd   = 1'b0;
        data     = reg_rdata;              // Registered one cycle after the strobe
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr, input dw_t exp);
        dw_t data;
        read_reg(addr, data);
        check_value(name, data, exp);
    endtask

    function automatic int draw_delay();
        return usr_slow ? int'($urandom_range(4, 10)) : int'($urandom_range(0, 1));
    endfunction

    task automatic wait_outstanding(input int target);
        int cycles;
        cycles = 0;
        while (outst < target && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (outst < target) begin
            $display("Timeout waiting for %0d outstanding words", target);
            timeouts++;
        end
    endtask

    task automatic wait_requests(input int target);
        int cycles;
        cycles = 0;
        while (req_cnt < target && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (req_cnt < target) begin
            $display("Timeout waiting for requests to resume");
            timeouts++;
        end
    endtask

    task automatic wait_done();
        dw_t status;
        int  polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < 3000) begin
            read_reg(`REG_STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            $display("Timeout waiting for done in the status register");
            timeouts++;
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || usr_req || usr_ack) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || usr_req || usr_ack) begin
            $display("Timeout with %0d words not delivered to the user", exp_q.size());
            timeouts++;
        end
    endtask

    task automatic start_transfer(input addr_t base, input int len, input int poison);
        int i;
        xfer_base  = base;
        xfer_len   = len;
        poison_idx = poison;
        req_words  = 0;
        req_cnt    = 0;
        cpl_cnt    = 0;
        exp_q.delete();
        for (i = 0; i < len; i++) begin
            if (i != poison) begin
                exp_q.push_back(base + addr_t'(4 * i));   // Data is the word's address
            end
        end
        write_reg(`REG_ADDR, base);
        write_reg(`REG_LEN, dw_t'(len));
        expect_reg("reg_rdata_o (ADDR)", `REG_ADDR, base);
        expect_reg("reg_rdata_o (LEN)", `REG_LEN, dw_t'(len));
        write_reg(`REG_CTRL, 32'h2);        // Clear done, err and count
        write_reg(`REG_CTRL, 32'h1);
        expect_reg("reg_rdata_o (STATUS)", `REG_STATUS, 32'h1);
    endtask

    task automatic finish_transfer();
        dw_t status_exp;
        wait_done();
        wait_drained();
        status_exp = (poison_idx >= 0) ? 32'h6 : 32'h2;
        expect_reg("reg_rdata_o (STATUS)", `REG_STATUS, status_exp);
        expect_reg("reg_rdata_o (RCVD)", `REG_RCVD, dw_t'(xfer_len));
        check_value("mrd_len_o total", dw_t'(req_words), dw_t'(xfer_len));
    endtask

    // --------------------
    // Link model
    // --------------------
    initial begin : link_model
        int    gap;
        int    i;
        int    exp_len;
        logic  offer_q;
        addr_t addr_q;
        len_t  len_q;
        tag_t  tag_q;
        gap       = 0;
        outst     = 0;
        offer_q   = 1'b0;
        addr_q    = '0;
        len_q     = '0;
        tag_q     = '0;
        mrd_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl_data  = '0;
        cpl_err   = 1'b0;
        forever begin
            @(negedge clk);
            if (offer_q) begin                   // Pending request must hold
                assert (mrd_valid && mrd_addr == addr_q && mrd_len == len_q && mrd_tag == tag_q)
                else begin
                    $display("Request changed or dropped before it was accepted");
                    proto_errs++;
                end
            end
            mrd_ready = rst_n && ($urandom_range(0, 3) != 0);
            if (mrd_valid && mrd_ready) begin
                exp_len = (xfer_len - req_words > `REQ_MAX_DW) ? `REQ_MAX_DW
                                                               : xfer_len - req_words;
                check_value("mrd_addr_o", mrd_addr, xfer_base + addr_t'(4 * req_words));
                check_value("mrd_len_o", dw_t'(mrd_len), dw_t'(exp_len));
                check_value("mrd_tag_o", dw_t'(mrd_tag), dw_t'(req_cnt % 32));
                for (i = 0; i < int'(mrd_len); i++) begin
                    pend_q.push_back(mrd_addr + addr_t'(4 * i));
                end
                req_words += int'(mrd_len);
                req_cnt++;
                outst += int'(mrd_len);
                assert (outst <= `CPL_CREDIT_DW) else begin
                    $display("Outstanding words %0d exceed the read credit", outst);
                    proto_errs++;
                end
            end
            offer_q = mrd_valid && !mrd_ready;
            addr_q  = mrd_addr;
            len_q   = mrd_len;
            tag_q   = mrd_tag;

            // Completions in request order
            cpl_valid = 1'b0;
            cpl_err   = 1'b0;
            if (rst_n && !cpl_ready) begin
                saw_full = 1'b1;
            end
            if (gap > 0) begin
                gap--;
            end else if (rst_n && !hold_cpl && pend_q.size() > 0) begin
                cpl_valid = 1'b1;
                cpl_data  = pend_q[0];
                cpl_err   = (cpl_cnt == poison_idx);
                if (cpl_ready) begin
                    void'(pend_q.pop_front());
                    cpl_cnt++;
                    outst--;
                    gap = $urandom_range(0, 2);
                end
            end
        end
    end

    // --------------------
    // User model
    // --------------------
    initial begin : user_model
        int   wait_cnt;
        logic req_q;
        logic ack_q;
        dw_t  data_q;
        dw_t  exp_word;
        wait_cnt = 0;
        req_q    = 1'b0;
        ack_q    = 1'b0;
        data_q   = '0;
        usr_ack  = 1'b0;
        forever begin
            @(negedge clk);
            if (req_q && !usr_req) begin
                assert (ack_q) else begin
                    $display("usr_req_o fell before usr_ack_i rose");
                    proto_errs++;
                end
            end
            if (req_q && usr_req) begin
                check_value("usr_data_o (held)", usr_data, data_q);
            end
            if (!req_q && usr_req) begin
                assert (!usr_ack) else begin
                    $display("usr_req_o rose while usr_ack_i was still high");
                    proto_errs++;
                end
            end
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else if (usr_req && !usr_ack) begin
                usr_ack = 1'b1;
                if (exp_q.size() == 0) begin
                    $display("User received an unexpected word %h", usr_data);
                    proto_errs++;
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("usr_data_o", usr_data, exp_word);
                end
                wait_cnt = draw_delay();
            end else if (!usr_req && usr_ack) begin
                usr_ack  = 1'b0;
                wait_cnt = draw_delay();
            end
            req_q  = usr_req;
            ack_q  = usr_ack;
            data_q = usr_data;
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin : main_seq
        seed_val   = $urandom(32'hff64_6208);
        rst_n      = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        hold_cpl   = 1'b0;
        usr_slow   = 1'b0;
        saw_full   = 1'b0;
        xfer_base  = '0;
        xfer_len   = 0;
        poison_idx = -1;
        req_words  = 0;
        req_cnt    = 0;
        cpl_cnt    = 0;
        val_errs   = 0;
        proto_errs = 0;
        timeouts   = 0;
        held       = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_value("mrd_valid_o", dw_t'(mrd_valid), 32'h0);
        check_value("usr_req_o", dw_t'(usr_req), 32'h0);
        check_value("cpl_ready_o", dw_t'(cpl_ready), 32'h1);
        for (a = 0; a <= 4; a++) begin
            expect_reg("reg_rdata_o (after reset)", reg_addr_t'(a), 32'h0);
        end

        // Plain transfer with request splitting
        start_transfer(32'h0000_1000, 45, -1);
        finish_transfer();

        // Withheld completions close the throttle
        hold_cpl = 1'b1;
        start_transfer(32'h0000_2000, 45, -1);
        wait_outstanding(`CPL_CREDIT_DW);
        held = req_cnt;
        repeat (40) @(negedge clk);
        assert (req_cnt == held && !mrd_valid) else begin
            $display("Request issued while completions were withheld");
            proto_errs++;
        end
        hold_cpl = 1'b0;
        wait_requests(held + 1);
        finish_transfer();

        // Slow user backs up into the buffer
        usr_slow = 1'b1;
        saw_full = 1'b0;
        start_transfer(32'h0000_3000, 64, -1);
        finish_transfer();
        assert (saw_full) else begin
            $display("cpl_ready_o never fell while the user was slow");
            proto_errs++;
        end
        usr_slow = 1'b0;

        // One poisoned word
        start_transfer(32'h0000_4000, 20, 7);
        finish_transfer();

        $display("Errors: %0d value, %0d protocol, %0d timeout", val_errs, proto_errs, timeouts);
        if (val_errs + proto_errs + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* hw/dma_ep_top.sv */
//--------------------
// Read DMA endpoint top level
// Register port, read request port, completion port and user drain
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_ep_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wr_i,
    input  logic               reg_rd_i,
    input  dma_pkg::reg_addr_t reg_addr_i,
    input  dma_pkg::dw_t       reg_wdata_i,
    output dma_pkg::dw_t       reg_rdata_o,
    output logic               mrd_valid_o,
    input  logic               mrd_ready_i,
    output dma_pkg::addr_t     mrd_addr_o,
    output dma_pkg::len_t      mrd_len_o,
    output dma_pkg::tag_t      mrd_tag_o,
    input  logic               cpl_valid_i,
    output logic               cpl_ready_o,
    input  dma_pkg::dw_t       cpl_data_i,
    input  logic               cpl_err_i,
    output logic               usr_req_o,
    input  logic               usr_ack_i,
    output dma_pkg::dw_t       usr_data_o
);
    import dma_pkg::*;

    logic  start;
    addr_t base_addr;
    len_t  xfer_len;
    logic  credit_ok;
    len_t  req_len;
    logic  req_fire;
    logic  cpl_word;
    logic  cpl_err;
    logic  buf_wr;
    dw_t   buf_wdata;
    logic  buf_full;
    logic  buf_pop;
    dw_t   buf_rdata;
    logic  buf_empty;

    // --------------------
    // Control and request side
    // --------------------
    dma_ctrl_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .start_o     (start),
        .base_addr_o (base_addr),
        .xfer_len_o  (xfer_len),
        .cpl_word_i  (cpl_word),
        .cpl_err_i   (cpl_err)
    );

    mrd_requester u_req (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .base_addr_i (base_addr),
        .xfer_len_i  (xfer_len),
        .credit_ok_i (credit_ok),
        .req_len_o   (req_len),
        .req_fire_o  (req_fire),
        .mrd_valid_o (mrd_valid_o),
        .mrd_ready_i (mrd_ready_i),
        .mrd_addr_o  (mrd_addr_o),
        .mrd_len_o   (mrd_len_o),
        .mrd_tag_o   (mrd_tag_o)
    );

    rd_throttle u_thr (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_len_i   (req_len),
        .req_fire_i  (req_fire),
        .cpl_word_i  (cpl_word),
        .credit_ok_o (credit_ok)
    );

    // --------------------
    // Completion chain
    // --------------------
    cpl_receiver u_rcv (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpl_valid_i (cpl_valid_i),
        .cpl_ready_o (cpl_ready_o),
        .cpl_data_i  (cpl_data_i),
        .cpl_err_i   (cpl_err_i),
        .buf_full_i  (buf_full),
        .buf_wr_o    (buf_wr),
        .buf_wdata_o (buf_wdata),
        .cpl_word_o  (cpl_word),
        .err_o       (cpl_err)
    );

    cpl_buffer #(
        .AW (`BUF_AW)
    ) u_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (buf_wr),
        .wdata_i (buf_wdata),
        .full_o  (buf_full),
        .rd_i    (buf_pop),
        .rdata_o (buf_rdata),
        .empty_o (buf_empty)
    );

    user_drain u_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty_i    (buf_empty),
        .rdata_i    (buf_rdata),
        .pop_o      (buf_pop),
        .usr_req_o  (usr_req_o),
        .usr_ack_i  (usr_ack_i),
        .usr_data_o (usr_data_o)
    );

endmodule

/* hw/cpl_path/user_drain.sv */
//--------------------
// User drain
// Four-phase req/ack handoff of buffered words
//--------------------

`timescale 1ns/1ps

module user_drain (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         empty_i,
    input  dma_pkg::dw_t rdata_i,
    output logic         pop_o,
    output logic         usr_req_o,
    input  logic         usr_ack_i,
    output dma_pkg::dw_t usr_data_o
);
    import dma_pkg::*;

    drain_state_t state_q;
    dw_t          data_q;

    assign usr_req_o  = (state_q == DRN_REQ);
    assign pop_o      = usr_req_o && usr_ack_i;   // Word taken by user
    assign usr_data_o = data_q;

    always_ff @(posedge clk) begin
        if (!empty_i && (state_q == DRN_IDLE)) begin
            data_q <= rdata_i;                    // Held through the handshake
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DRN_IDLE;
        end else begin
            case (state_q)
                DRN_IDLE: begin
                    if (!empty_i) begin
                        state_q <= DRN_REQ;
                    end
                end
                DRN_REQ: begin
                    if (usr_ack_i) begin
                        state_q <= DRN_WAIT_ACK_LOW;
                    end
                end
                DRN_WAIT_ACK_LOW: begin
                    if (!usr_ack_i) begin
                        state_q <= DRN_IDLE;  // Ready for next word
                    end
                end
                default: state_q <= DRN_IDLE;
            endcase
        end
    end

endmodule

/* hw/cpl_path/cpl_buffer.sv */
//--------------------
// Completion buffer
// Single-clock FIFO with show-ahead read data
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module cpl_buffer #(
    parameter int AW = `BUF_AW
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         wr_i,
    input  dma_pkg::dw_t wdata_i,
    output logic         full_o,
    input  logic         rd_i,
    output dma_pkg::dw_t rdata_o,
    output logic         empty_o
);
    import dma_pkg::*;

    dw_t           mem_q [2**AW];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   cnt_q;
    logic          do_wr;
    logic          do_rd;

    assign full_o  = cnt_q[AW];          // Top bit set only at 2**AW
    assign empty_o = (cnt_q == '0);
    assign do_wr   = wr_i && !full_o;
    assign do_rd   = rd_i && !empty_o;
    assign rdata_o = mem_q[rd_ptr_q];    // Head word

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

/* hw/cpl_path/cpl_receiver.sv */
//--------------------
// Completion receiver
// Accepts completion words, stores good ones, reports count and errors
//--------------------

`timescale 1ns/1ps

module cpl_receiver (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cpl_valid_i,
    output logic         cpl_ready_o,
    input  dma_pkg::dw_t cpl_data_i,
    input  logic         cpl_err_i,
    input  logic         buf_full_i,
    output logic         buf_wr_o,
    output dma_pkg::dw_t buf_wdata_o,
    output logic         cpl_word_o,
    output logic         err_o
);

    logic cpl_fire;
    logic word_q;
    logic err_q;

    // --------------------
    // Intake
    // --------------------
    assign cpl_ready_o = !buf_full_i;                 // Stall only on a full buffer
    assign cpl_fire    = cpl_valid_i && cpl_ready_o;

    // Poisoned words are dropped here
    assign buf_wr_o    = cpl_fire && !cpl_err_i;
    assign buf_wdata_o = cpl_data_i;

    // --------------------
    // Per-word pulses
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            word_q <= cpl_fire;                       // Good or poisoned
            err_q  <= cpl_fire && cpl_err_i;
        end
    end

    assign cpl_word_o = word_q;
    assign err_o      = err_q;

endmodule

/* hw/mrd_path/rd_throttle.sv */
//--------------------
// Read throttle
// Limits outstanding requested words to CPL_CREDIT_DW
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module rd_throttle (
    input  logic          clk,
    input  logic          rst_n,
    input  dma_pkg::len_t req_len_i,
    input  logic          req_fire_i,
    input  logic          cpl_word_i,
    output logic          credit_ok_o
);
    import dma_pkg::*;

    len_t             outst_q;
    logic [`LEN_W:0]  need;    // One extra bit against overflow

    assign need        = {1'b0, outst_q} + {1'b0, req_len_i};
    assign credit_ok_o = (need <= `CPL_CREDIT_DW);

    // Outstanding word count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outst_q <= '0;
        end else begin
            case ({req_fire_i, cpl_word_i})
                2'b10:   outst_q <= outst_q + req_len_i;         // Request sent
                2'b01:   outst_q <= outst_q - 1'b1;              // Word returned
                2'b11:   outst_q <= outst_q + req_len_i - 1'b1;
                default: outst_q <= outst_q;
            endcase
        end
    end

endmodule

/* hw/mrd_path/mrd_requester.sv */
//--------------------
// Memory read requester
// Splits a transfer into read requests of at most REQ_MAX_DW words
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module mrd_requester (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start_i,
    input  dma_pkg::addr_t base_addr_i,
    input  dma_pkg::len_t  xfer_len_i,
    input  logic           credit_ok_i,
    output dma_pkg::len_t  req_len_o,
    output logic           req_fire_o,
    output logic           mrd_valid_o,
    input  logic           mrd_ready_i,
    output dma_pkg::addr_t mrd_addr_o,
    output dma_pkg::len_t  mrd_len_o,
    output dma_pkg::tag_t  mrd_tag_o
);
    import dma_pkg::*;

    req_state_t state_q;
    len_t       remain_q;
    addr_t      addr_q;
    tag_t       tag_q;

    // Next request size, held stable through ISSUE
    assign req_len_o = (remain_q > len_t'(`REQ_MAX_DW)) ? len_t'(`REQ_MAX_DW) : remain_q;

    assign mrd_valid_o = (state_q == REQ_ISSUE);
    assign req_fire_o  = mrd_valid_o && mrd_ready_i;
    assign mrd_addr_o  = addr_q;
    assign mrd_len_o   = req_len_o;
    assign mrd_tag_o   = tag_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= REQ_IDLE;
            remain_q <= '0;
            addr_q   <= '0;
            tag_q    <= '0;
        end else begin
            case (state_q)
                REQ_IDLE: begin
                    if (start_i) begin
                        remain_q <= xfer_len_i;
                        addr_q   <= base_addr_i;
                        tag_q    <= '0;
                        if (xfer_len_i != '0) begin
                            state_q <= REQ_WAIT_CREDIT;
                        end
                    end
                end
                REQ_WAIT_CREDIT: begin
                    if (credit_ok_i) begin
                        state_q <= REQ_ISSUE;   // Room for this request
                    end
                end
                REQ_ISSUE: begin
                    if (mrd_ready_i) begin
                        remain_q <= remain_q - req_len_o;
                        addr_q   <= addr_q + addr_t'({req_len_o, 2'b00});
                        tag_q    <= tag_q + 1'b1;   // Wraps at 32
                        state_q  <= (remain_q == req_len_o) ? REQ_IDLE : REQ_WAIT_CREDIT;
                    end
                end
                default: state_q <= REQ_IDLE;
            endcase
        end
    end

endmodule

/* hw/dma_ctrl_regs.sv */
//--------------------
// DMA control and status registers
// Holds base, length and error state, tracks busy and done
//--------------------

`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_ctrl_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wr_i,
    input  logic               reg_rd_i,
    input  dma_pkg::reg_addr_t reg_addr_i,
    input  dma_pkg::dw_t       reg_wdata_i,
    output dma_pkg::dw_t       reg_rdata_o,
    output logic               start_o,
    output dma_pkg::addr_t     base_addr_o,
    output dma_pkg::len_t      xfer_len_o,
    input  logic               cpl_word_i,
    input  logic               cpl_err_i
);
    import dma_pkg::*;

    addr_t base_q;
    len_t  len_q;
    len_t  rcvd_q;
    logic  busy_q;
    logic  done_q;
    logic  err_q;
    logic  start_q;
    dw_t   rdata_q;
    dw_t   rd_mux;
    logic  ctrl_wr;
    logic  start_req;
    logic  clr_req;

    assign ctrl_wr   = reg_wr_i && (reg_addr_i == `REG_CTRL);
    assign start_req = ctrl_wr && reg_wdata_i[0] && !busy_q;  // Ignored while busy
    assign clr_req   = ctrl_wr && reg_wdata_i[1];

    // --------------------
    // Register writes and progress
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            base_q  <= '0;
            len_q   <= '0;
            rcvd_q  <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
            start_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            start_q <= start_req;
            if (reg_wr_i && (reg_addr_i == `REG_ADDR)) begin
                base_q <= reg_wdata_i;
            end
            if (reg_wr_i && (reg_addr_i == `REG_LEN)) begin
                len_q <= reg_wdata_i[`LEN_W-1:0];
            end

            if (clr_req || start_req) begin
                rcvd_q <= '0;               // Fresh count per transfer
            end else if (cpl_word_i) begin
                rcvd_q <= rcvd_q + 1'b1;
            end

            if (start_req) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (busy_q && (rcvd_q == len_q)) begin
                busy_q <= 1'b0;             // All words back
                done_q <= 1'b1;
            end else if (clr_req) begin
                done_q <= 1'b0;
            end

            if (clr_req) begin
                err_q <= 1'b0;
            end else if (cpl_err_i) begin
                err_q <= 1'b1;              // Sticky until cleared
            end

            if (reg_rd_i) begin
                rdata_q <= rd_mux;
            end
        end
    end

    // Read data select
    always_comb begin
        case (reg_addr_i)
            `REG_ADDR:   rd_mux = base_q;
            `REG_LEN:    rd_mux = dw_t'(len_q);
            `REG_STATUS: rd_mux = dw_t'({err_q, done_q, busy_q});
            `REG_RCVD:   rd_mux = dw_t'(rcvd_q);
            default:     rd_mux = '0;       // CTRL reads back zero
        endcase
    end

    assign reg_rdata_o = rdata_q;
    assign start_o     = start_q;
    assign base_addr_o = base_q;
    assign xfer_len_o  = len_q;

endmodule

/* common/dma_pkg.sv */
//--------------------
// Shared types for the read DMA endpoint
//--------------------

`include "dma_defs.svh"

package dma_pkg;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [`DW_W-1:0]   dw_t;        // One data word
    typedef logic [`ADDR_W-1:0] addr_t;      // Byte address
    typedef logic [`LEN_W-1:0]  len_t;       // Word count
    typedef logic [`TAG_W-1:0]  tag_t;       // Request tag
    typedef logic [`REG_AW-1:0] reg_addr_t;  // Register address

    // --------------------
    // FSM states
    // --------------------
    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_ISSUE,
        REQ_WAIT_CREDIT
    } req_state_t;

    typedef enum logic [1:0] {
        DRN_IDLE,
        DRN_REQ,
        DRN_WAIT_ACK_LOW
    } drain_state_t;

endpackage

/* common/dma_defs.svh */
//--------------------
// Read DMA endpoint widths, limits
// and register map
//--------------------

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Data path widths
`define DW_W          32
`define ADDR_W        32
`define LEN_W         16
`define TAG_W         5

// Request sizing and read credit
`define REQ_MAX_DW    8    // Largest single read request in words
`define CPL_CREDIT_DW 32   // Outstanding word limit
`define BUF_AW        5    // Completion buffer depth is 2**BUF_AW

// Register map
`define REG_AW        3
`define REG_CTRL      3'd0
`define REG_ADDR      3'd1
`define REG_LEN       3'd2
`define REG_STATUS    3'd3
`define REG_RCVD      3'd4

`endif
